//--- design/lsab_consts.svh
`ifndef LSAB_CONSTS_SVH
`define LSAB_CONSTS_SVH

// number of queues sharing the RAM
`define LSAB_QUEUES 4

// pointer width inside one 64-word region
`define LSAB_PTR_BITS 6

`define LSAB_WORD_BITS 32

`define LSAB_CAPACITY 63

`endif

//--- design/lsab_pkg.sv
`include "lsab_consts.svh"
`default_nettype none

package lsab_pkg;

  typedef logic [$clog2(`LSAB_QUEUES)-1:0] qsel_t;

  typedef logic [`LSAB_WORD_BITS-1:0] word_t;

  typedef logic [`LSAB_PTR_BITS-1:0] qlen_t;

  // one request from the bus port, push and pop are single-cycle pulses
  typedef struct packed {
    logic  push;
    logic  pop;
    qsel_t qsel;
    word_t wdata;
  } queue_cmd_t;

  typedef struct packed {
    logic  valid;
    logic  ok;     // low on full push or empty pop
    word_t rdata;
  } queue_done_t;

  typedef struct packed {
    qlen_t len;
    logic  full;
    logic  empty;
  } queue_status_t;

  typedef queue_status_t [`LSAB_QUEUES-1:0] status_vec_t;

endpackage

`default_nettype wire

//--- design/shared_sram.sv
`default_nettype none

module shared_sram (
  input  wire                  CLK,
  input  wire                  we,
  input  wire  [7:0]           waddr,
  input  wire lsab_pkg::word_t wdata,
  input  wire                  re,
  input  wire  [7:0]           raddr,
  output lsab_pkg::word_t      rdata
);

  localparam int DEPTH = 2 ** 8;

  lsab_pkg::word_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port
  always_ff @(posedge CLK) begin
    if (re) begin
      rdata <= mem[raddr];  // holds while re is low
    end
  end

  a_waddr_known : assert property (@(posedge CLK) we |-> !$isunknown(waddr))
    else $error("shared_sram: write with unknown address");

endmodule

`default_nettype wire

//--- design/lsab_queues.sv
`include "lsab_consts.svh"
`default_nettype none

module lsab_queues (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire lsab_pkg::queue_cmd_t cmd,
  output lsab_pkg::queue_done_t     wr_done,
  output lsab_pkg::queue_done_t     rd_done,
  output lsab_pkg::status_vec_t     status
);

  localparam int QUEUES   = `LSAB_QUEUES;
  localparam int PTR_BITS = `LSAB_PTR_BITS;
  localparam lsab_pkg::qlen_t CAPACITY = lsab_pkg::qlen_t'(`LSAB_CAPACITY);

  // per-queue state
  logic [PTR_BITS-1:0] wptr  [QUEUES];
  logic [PTR_BITS-1:0] rptr  [QUEUES];
  lsab_pkg::qlen_t     len   [QUEUES];
  logic                full  [QUEUES];
  logic                empty [QUEUES];

  logic              do_push;
  logic              do_pop;
  logic [QUEUES-1:0] q_push;
  logic [QUEUES-1:0] q_pop;

  logic [7:0]      ram_waddr;
  logic [7:0]      ram_raddr;
  lsab_pkg::word_t ram_rdata;

  // first pop stage lines up with the RAM read
  logic pop_valid_d;
  logic pop_ok_d;

  assign do_push = cmd.push && !full[cmd.qsel];   // full queue drops push
  assign do_pop  = cmd.pop && !empty[cmd.qsel];   // empty queue drops pop

  always_comb begin
    q_push = '0;
    q_pop  = '0;
    q_push[cmd.qsel] = do_push;
    q_pop[cmd.qsel]  = do_pop;
  end

  // queue index picks the 64-word region
  assign ram_waddr = {cmd.qsel, wptr[cmd.qsel]};
  assign ram_raddr = {cmd.qsel, rptr[cmd.qsel]};

  shared_sram u_sram (
    .CLK   (CLK),
    .we    (do_push),
    .waddr (ram_waddr),
    .wdata (cmd.wdata),
    .re    (do_pop),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

  for (genvar q = 0; q < QUEUES; q++) begin : g_queue
    lsab_pkg::qlen_t len_next;
    lsab_pkg::qlen_t fill;

    assign fill = wptr[q] - rptr[q];  // words between the pointers

    always_comb begin
      case ({q_pop[q], q_push[q]})
        2'b10:   len_next = len[q] - 1'b1;
        2'b01:   len_next = len[q] + 1'b1;
        default: len_next = len[q];  // idle, or push and pop cancel out
      endcase
    end

    always_ff @(posedge CLK) begin
      if (!RST) begin
        len[q]   <= '0;
        full[q]  <= 1'b0;
        empty[q] <= 1'b1;
        wptr[q]  <= '0;
        rptr[q]  <= '0;
      end else begin
        len[q]   <= len_next;
        full[q]  <= (len_next == CAPACITY);
        empty[q] <= (len_next == '0);
        if (q_push[q]) begin
          wptr[q] <= wptr[q] + 1'b1;  // wraps inside region
        end
        if (q_pop[q]) begin
          rptr[q] <= rptr[q] + 1'b1;
        end
      end
    end

    assign status[q] = '{len: len[q], full: full[q], empty: empty[q]};

    a_len_cap : assert property (@(posedge CLK) disable iff (!RST)
      q_push[q] |-> len[q] < CAPACITY)
      else $error("lsab_queues: queue %0d push past capacity", q);

    a_flags : assert property (@(posedge CLK) disable iff (!RST)
      full[q] == (fill == CAPACITY) && empty[q] == (fill == '0))
      else $error("lsab_queues: queue %0d flags disagree with pointers", q);
  end

  // push result one cycle after the command, pop result two cycles after
  always_ff @(posedge CLK) begin
    if (!RST) begin
      wr_done     <= '0;
      rd_done     <= '0;
      pop_valid_d <= 1'b0;
      pop_ok_d    <= 1'b0;
    end else begin
      wr_done.valid <= cmd.push;
      wr_done.ok    <= do_push;
      wr_done.rdata <= '0;

      pop_valid_d <= cmd.pop;
      pop_ok_d    <= do_pop;

      rd_done.valid <= pop_valid_d;
      rd_done.ok    <= pop_ok_d;
      rd_done.rdata <= pop_ok_d ? ram_rdata : '0;  // zero on empty pop
    end
  end

  // the bus port issues one operation at a time
  a_one_op : assert property (@(posedge CLK) disable iff (!RST)
    !(cmd.push && cmd.pop))
    else $error("lsab_queues: push and pop in the same cycle");

endmodule

`default_nettype wire

//--- design/wb_queue_port.sv
`default_nettype none

module wb_queue_port (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        cyc,
  input  wire                        stb,
  input  wire                        we,
  input  wire  [4:0]                 adr,
  input  wire lsab_pkg::word_t       dat_w,
  output lsab_pkg::word_t            dat_r,
  output logic                       ack,
  output logic                       err,
  output lsab_pkg::queue_cmd_t       cmd,
  input  wire lsab_pkg::queue_done_t wr_done,
  input  wire lsab_pkg::queue_done_t rd_done,
  input  wire lsab_pkg::status_vec_t status
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,     // issue command, then wait for its result
    ST_RESP,     // ack or err high
    ST_RELEASE   // wait for stb low
  } state_t;

  state_t state;

  logic accept;
  logic req_new;   // first cycle in ST_WAIT
  logic cmd_push;
  logic cmd_pop;

  // captured bus request
  logic            req_we;
  logic            req_stat;
  lsab_pkg::qsel_t req_qsel;
  lsab_pkg::word_t req_wdata;

  lsab_pkg::queue_done_t done;
  lsab_pkg::word_t       status_word;

  assign accept = (state == ST_IDLE) && cyc && stb;

  assign done = req_we ? wr_done : rd_done;

  assign cmd = '{push: cmd_push, pop: cmd_pop, qsel: req_qsel, wdata: req_wdata};

  // len in 5..0, full in 8, empty in 9
  always_comb begin
    status_word     = '0;
    status_word[5:0] = status[req_qsel].len;
    status_word[8]   = status[req_qsel].full;
    status_word[9]   = status[req_qsel].empty;
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      state    <= ST_IDLE;
      req_new  <= 1'b0;
      cmd_push <= 1'b0;
      cmd_pop  <= 1'b0;
      ack      <= 1'b0;
      err      <= 1'b0;
    end else begin
      req_new  <= 1'b0;
      cmd_push <= 1'b0;
      cmd_pop  <= 1'b0;
      ack      <= 1'b0;
      err      <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            req_new <= 1'b1;
            state   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (req_new) begin
            if (req_stat) begin
              ack   <= !req_we;
              err   <= req_we;  // status is read only
              state <= ST_RESP;
            end else begin
              cmd_push <= req_we;
              cmd_pop  <= !req_we;
            end
          end else if (done.valid) begin
            ack   <= done.ok;
            err   <= !done.ok;
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          state <= stb ? ST_RELEASE : ST_IDLE;
        end
        ST_RELEASE: begin
          if (!stb) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      req_we    <= we;
      req_stat  <= adr[4];
      req_qsel  <= adr[3:2];
      req_wdata <= dat_w;
    end
    if (state == ST_WAIT && req_new && req_stat && !req_we) begin
      dat_r <= status_word;
    end else if (state == ST_WAIT && !req_new && !req_we && rd_done.valid) begin
      dat_r <= rd_done.rdata;  // popped word
    end
  end

  a_done_in_wait : assert property (@(posedge CLK) disable iff (!RST)
    (wr_done.valid || rd_done.valid) |-> state == ST_WAIT && !req_new)
    else $error("wb_queue_port: completion outside a pending request");

endmodule

`default_nettype wire

//--- design/lsab_top.sv
`default_nettype none

module lsab_top (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  cyc,
  input  wire                  stb,
  input  wire                  we,
  input  wire  [4:0]           adr,
  input  wire lsab_pkg::word_t dat_w,
  output lsab_pkg::word_t      dat_r,
  output logic                 ack,
  output logic                 err
);

  lsab_pkg::queue_cmd_t  cmd;
  lsab_pkg::queue_done_t wr_done;
  lsab_pkg::queue_done_t rd_done;
  lsab_pkg::status_vec_t status;

  // bus side
  wb_queue_port u_port (
    .CLK     (CLK),
    .RST     (RST),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .err     (err),
    .cmd     (cmd),
    .wr_done (wr_done),
    .rd_done (rd_done),
    .status  (status)
  );

  // four queues over the shared RAM
  lsab_queues u_queues (
    .CLK     (CLK),
    .RST     (RST),
    .cmd     (cmd),
    .wr_done (wr_done),
    .rd_done (rd_done),
    .status  (status)
  );

endmodule

`default_nettype wire

//--- tb/lsab_tb.sv
`include "lsab_consts.svh"
`default_nettype none

module lsab_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RANDOM_OPS = 2000;
  localparam int OP_BUDGET  = 2 * RANDOM_OPS + 1000;  // random traffic plus directed tests
  localparam int BUS_LIMIT  = 16;                     // cycles allowed per bus cycle
  localparam int SEED       = 32'h42a0_b209;
  localparam int FULL_Q     = 2;

  logic            CLK;
  logic            RST;
  logic            cyc;
  logic            stb;
  logic            we;
  logic [4:0]      adr;
  lsab_pkg::word_t dat_w;
  lsab_pkg::word_t dat_r;
  logic            ack;
  logic            err;

  // reference queues, one per hardware queue
  lsab_pkg::word_t model_q [`LSAB_QUEUES][$];

  lsab_top UUT (
    .CLK   (CLK),
    .RST   (RST),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .err   (err)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    #(OP_BUDGET * 6 * 8 * 2);
    $display("Timeout: the simulation did not finish within its time limit at %0t ns", $time);
    stop_on_failure();
  end

  task automatic stop_on_failure();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_word(input lsab_pkg::word_t expected, input lsab_pkg::word_t actual,
                            input string what);
    if (actual !== expected) begin
      report_mismatch($sformatf("%s: expected %08h, got %08h", what, expected, actual));
    end
  endtask

  task automatic check_status(input lsab_pkg::queue_status_t expected,
                              input lsab_pkg::queue_status_t actual, input int q);
    if (actual !== expected) begin
      report_mismatch($sformatf(
        "status of queue %0d: expected len %0d full %b empty %b, got len %0d full %b empty %b",
        q, expected.len, expected.full, expected.empty,
        actual.len, actual.full, actual.empty));
    end
  endtask

  task automatic check_resp(input logic exp_ok, input logic got_ack, input logic got_err,
                            input string what);
    if (got_ack !== exp_ok || got_err !== !exp_ok) begin
      report_mismatch($sformatf("%s: expected %s, got ack %b err %b",
                                what, exp_ok ? "ack" : "err", got_ack, got_err));
    end
  endtask

  // one classic cycle entered and left 1 ns after a rising edge
  task automatic bus_transfer(input logic wr, input logic stat, input lsab_pkg::qsel_t q,
                              input lsab_pkg::word_t wdata, output logic got_ack,
                              output logic got_err, output lsab_pkg::word_t rdata);
    int waited;
    waited = 0;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = {stat, q, 2'b00};
    dat_w = wdata;
    @(posedge CLK);
    #1;
    while (!ack && !err) begin
      if (waited == BUS_LIMIT) begin
        $display("Bus error: no ack or err within %0d cycles at %0t ns", BUS_LIMIT, $time);
        stop_on_failure();
      end
      waited++;
      @(posedge CLK);
      #1;
    end
    got_ack = ack;
    got_err = err;
    rdata   = dat_r;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    @(posedge CLK);  // stb low for a cycle
    #1;
  endtask

  task automatic bus_write(input logic stat, input lsab_pkg::qsel_t q,
                           input lsab_pkg::word_t wdata, output logic got_ack,
                           output logic got_err);
    lsab_pkg::word_t unused;
    bus_transfer(1'b1, stat, q, wdata, got_ack, got_err, unused);
  endtask

  task automatic bus_read(input logic stat, input lsab_pkg::qsel_t q,
                          output lsab_pkg::word_t rdata, output logic got_ack,
                          output logic got_err);
    bus_transfer(1'b0, stat, q, '0, got_ack, got_err, rdata);
  endtask

  function automatic lsab_pkg::queue_status_t model_status(input int q);
    lsab_pkg::queue_status_t st;
    st.len   = lsab_pkg::qlen_t'(model_q[q].size());
    st.full  = (model_q[q].size() == `LSAB_CAPACITY);
    st.empty = (model_q[q].size() == 0);
    return st;
  endfunction

  task automatic push_word(input lsab_pkg::qsel_t q, input lsab_pkg::word_t data);
    logic exp_ok;
    logic got_ack;
    logic got_err;
    exp_ok = (model_q[q].size() < `LSAB_CAPACITY);
    bus_write(1'b0, q, data, got_ack, got_err);
    check_resp(exp_ok, got_ack, got_err, $sformatf("push to queue %0d", q));
    if (exp_ok) begin
      model_q[q].push_back(data);
    end
  endtask

  task automatic pop_word(input lsab_pkg::qsel_t q);
    logic            exp_ok;
    logic            got_ack;
    logic            got_err;
    lsab_pkg::word_t rdata;
    exp_ok = (model_q[q].size() > 0);
    bus_read(1'b0, q, rdata, got_ack, got_err);
    check_resp(exp_ok, got_ack, got_err, $sformatf("pop from queue %0d", q));
    if (exp_ok) begin
      check_word(model_q[q].pop_front(), rdata, $sformatf("pop data of queue %0d", q));
    end
  endtask

  task automatic read_status(input lsab_pkg::qsel_t q);
    logic                    got_ack;
    logic                    got_err;
    lsab_pkg::word_t         rdata;
    lsab_pkg::queue_status_t seen;
    bus_read(1'b1, q, rdata, got_ack, got_err);
    check_resp(1'b1, got_ack, got_err, $sformatf("status read of queue %0d", q));
    seen.len   = rdata[5:0];
    seen.full  = rdata[8];
    seen.empty = rdata[9];
    check_status(model_status(q), seen, q);
  endtask

  task automatic write_status_reg(input lsab_pkg::qsel_t q);
    logic got_ack;
    logic got_err;
    bus_write(1'b1, q, $urandom(), got_ack, got_err);
    check_resp(1'b0, got_ack, got_err, $sformatf("status write of queue %0d", q));
  endtask

  initial begin
    lsab_pkg::qsel_t q;
    int              pick;
    int              pushpop_done;

    void'($urandom(SEED));
    RST   = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b1;

    // all queues empty out of reset
    for (int i = 0; i < `LSAB_QUEUES; i++) begin
      read_status(lsab_pkg::qsel_t'(i));
    end

    // random pushes and pops with status reads mixed in
    pushpop_done = 0;
    while (pushpop_done < RANDOM_OPS) begin
      q    = lsab_pkg::qsel_t'($urandom_range(`LSAB_QUEUES - 1));
      pick = $urandom_range(99);
      if (pick < 20) begin
        read_status(q);
      end else if (pick < 65) begin
        push_word(q, $urandom());
        pushpop_done++;
      end else begin
        pop_word(q);
        pushpop_done++;
      end
    end

    // status register is read only
    for (int i = 0; i < `LSAB_QUEUES; i++) begin
      write_status_reg(lsab_pkg::qsel_t'(i));
      read_status(lsab_pkg::qsel_t'(i));
    end

    // empty one queue, then fill it past capacity
    while (model_q[FULL_Q].size() > 0) begin
      pop_word(lsab_pkg::qsel_t'(FULL_Q));
    end
    for (int i = 0; i < `LSAB_CAPACITY + 1; i++) begin
      push_word(lsab_pkg::qsel_t'(FULL_Q), $urandom());  // last one must get err
    end
    read_status(lsab_pkg::qsel_t'(FULL_Q));

    // draining checks the other queues kept their words
    for (int i = 0; i < `LSAB_QUEUES; i++) begin
      while (model_q[i].size() > 0) begin
        pop_word(lsab_pkg::qsel_t'(i));
      end
    end

    // pops from empty queues
    for (int i = 0; i < `LSAB_QUEUES; i++) begin
      pop_word(lsab_pkg::qsel_t'(i));
      read_status(lsab_pkg::qsel_t'(i));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/lsab_pkg.sv
design/shared_sram.sv
design/lsab_queues.sv
design/wb_queue_port.sv
design/lsab_top.sv
tb/lsab_tb.sv
